// File: common/ex_pkg.sv
package ex_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int DATA_W     = 64;
    localparam int DATA_EXT_W = DATA_W + 1;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_EXT_W-1:0] data_ext_t;
    typedef logic [31:0]           instr_t;
    typedef logic [5:0]            shamt_t;
    typedef logic [2:0]            wb_adr_t;

    // ==================================================
    // alu and shifter controls
    // ==================================================
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_OP_NONE = 3'd0;
    localparam alu_op_t ALU_OP_ADD  = 3'd3;
    localparam alu_op_t ALU_OP_SUB  = 3'd4;
    localparam alu_op_t ALU_OP_XOR  = 3'd5;
    localparam alu_op_t ALU_OP_OR   = 3'd6;
    localparam alu_op_t ALU_OP_AND  = 3'd7;

    typedef logic [1:0] shift_kind_t;

    localparam shift_kind_t SHIFT_NONE = 2'd0;
    localparam shift_kind_t SHIFT_SLL  = 2'd1;
    localparam shift_kind_t SHIFT_SRL  = 2'd2;
    localparam shift_kind_t SHIFT_SRA  = 2'd3;

    // major opcodes handled by the unit
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    // ==================================================
    // register map
    // ==================================================
    localparam wb_adr_t REG_OP1    = 3'd0;
    localparam wb_adr_t REG_OP2    = 3'd1;
    localparam wb_adr_t REG_INSTR  = 3'd2;
    localparam wb_adr_t REG_RESULT = 3'd3;
    localparam wb_adr_t REG_STATUS = 3'd4;

    // status word bit positions
    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;
    localparam int STAT_ILLEGAL = 2;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ISSUE,
        CTRL_DONE
    } ctrl_state_t;

endpackage

// File: design/ex_decode.sv
`timescale 1ns/1ps

module ex_decode import ex_pkg::*; (
    input  instr_t      instr_i,
    output alu_op_t     alu_op_o,
    output logic        slt_signed_o,
    output logic        slt_unsigned_o,
    output shift_kind_t shift_kind_o,
    output logic        use_imm_o,
    output data_t       imm_o,
    output logic        word_o,
    output logic        illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;
    logic       f6_zero;
    logic       f6_alt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;
    // 64-bit immediate shifts keep shamt[5] in bit 25
    assign f6_zero = funct7[6:1] == 6'b000000;
    assign f6_alt  = funct7[6:1] == 6'b010000;

    // i-type immediate, its low six bits double as shamt
    assign imm_o = {{(DATA_W-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        alu_op_o       = ALU_OP_NONE;
        slt_signed_o   = 1'b0;
        slt_unsigned_o = 1'b0;
        shift_kind_o   = SHIFT_NONE;
        use_imm_o      = 1'b0;
        word_o         = 1'b0;
        illegal_o      = 1'b0;

        case (opcode)
            OPC_OP: begin
                if (f7_zero) begin
                    case (funct3)
                        3'b000: alu_op_o = ALU_OP_ADD;
                        3'b001: shift_kind_o = SHIFT_SLL;
                        3'b010: begin
                            alu_op_o     = ALU_OP_SUB;
                            slt_signed_o = 1'b1;
                        end
                        3'b011: begin
                            alu_op_o       = ALU_OP_SUB;
                            slt_unsigned_o = 1'b1;
                        end
                        3'b100: alu_op_o = ALU_OP_XOR;
                        3'b101: shift_kind_o = SHIFT_SRL;
                        3'b110: alu_op_o = ALU_OP_OR;
                        default: alu_op_o = ALU_OP_AND;
                    endcase
                end else if (f7_alt && funct3 == 3'b000) begin
                    alu_op_o = ALU_OP_SUB;
                end else if (f7_alt && funct3 == 3'b101) begin
                    shift_kind_o = SHIFT_SRA;
                end else begin
                    illegal_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_OP_ADD;
                    3'b010: begin
                        alu_op_o     = ALU_OP_SUB;
                        slt_signed_o = 1'b1;
                    end
                    3'b011: begin
                        alu_op_o       = ALU_OP_SUB;
                        slt_unsigned_o = 1'b1;
                    end
                    3'b100: alu_op_o = ALU_OP_XOR;
                    3'b110: alu_op_o = ALU_OP_OR;
                    3'b111: alu_op_o = ALU_OP_AND;
                    3'b001: begin
                        if (f6_zero) shift_kind_o = SHIFT_SLL;
                        else illegal_o = 1'b1;
                    end
                    default: begin
                        if (f6_zero) shift_kind_o = SHIFT_SRL;
                        else if (f6_alt) shift_kind_o = SHIFT_SRA;
                        else illegal_o = 1'b1;
                    end
                endcase
            end
            OPC_OP_32: begin
                word_o = 1'b1;
                if (funct3 == 3'b000 && f7_zero) alu_op_o = ALU_OP_ADD;
                else if (funct3 == 3'b000 && f7_alt) alu_op_o = ALU_OP_SUB;
                else if (funct3 == 3'b001 && f7_zero) shift_kind_o = SHIFT_SLL;
                else if (funct3 == 3'b101 && f7_zero) shift_kind_o = SHIFT_SRL;
                else if (funct3 == 3'b101 && f7_alt) shift_kind_o = SHIFT_SRA;
                else illegal_o = 1'b1;
            end
            OPC_OP_IMM_32: begin
                word_o    = 1'b1;
                use_imm_o = 1'b1;
                // full funct7 check, so shamt[5] set is illegal here
                if (funct3 == 3'b000) alu_op_o = ALU_OP_ADD;
                else if (funct3 == 3'b001 && f7_zero) shift_kind_o = SHIFT_SLL;
                else if (funct3 == 3'b101 && f7_zero) shift_kind_o = SHIFT_SRL;
                else if (funct3 == 3'b101 && f7_alt) shift_kind_o = SHIFT_SRA;
                else illegal_o = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

// File: design/ex_alu.sv
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  alu_op_t alu_op_i,
    input  logic    inst_slt_nu_i,
    input  logic    inst_slt_u_i,
    input  data_t   op1_i,
    input  data_t   op2_i,
    output data_t   res_data_o
);

    logic      alu_add;
    logic      alu_sub;
    logic      alu_xor;
    logic      alu_or;
    logic      alu_and;
    logic      is_slt;
    logic      op_signed;
    logic      use_arith;

    data_t     slt_res;
    data_ext_t ext_op1;
    data_ext_t ext_op2;
    data_ext_t addend;
    data_ext_t arith_res;
    data_ext_t xor_res;
    data_ext_t or_res;
    data_ext_t and_res;
    data_ext_t res_pre;

    assign alu_add   = alu_op_i == ALU_OP_ADD;
    assign alu_sub   = alu_op_i == ALU_OP_SUB;
    assign alu_xor   = alu_op_i == ALU_OP_XOR;
    assign alu_or    = alu_op_i == ALU_OP_OR;
    assign alu_and   = alu_op_i == ALU_OP_AND;
    assign is_slt    = inst_slt_nu_i | inst_slt_u_i;
    assign op_signed = ~inst_slt_u_i;
    assign use_arith = alu_add | (alu_sub & ~is_slt);

    // one extra bit so bit 64 of the difference is the less-than flag
    assign ext_op1 = {op_signed & op1_i[DATA_W-1], op1_i};
    assign ext_op2 = {op_signed & op2_i[DATA_W-1], op2_i};

    assign addend    = alu_sub ? (~ext_op2 + DATA_EXT_W'(1)) : ext_op2;
    assign arith_res = ext_op1 + addend;
    assign xor_res   = ext_op1 ^ ext_op2;
    assign or_res    = ext_op1 | ext_op2;
    assign and_res   = ext_op1 & ext_op2;

    assign slt_res = {{(DATA_W-1){1'b0}}, arith_res[DATA_W]};

    always_comb begin
        res_pre = '0;
        if (use_arith) begin
            res_pre = arith_res;
        end else if (alu_xor) begin
            res_pre = xor_res;
        end else if (alu_or) begin
            res_pre = or_res;
        end else if (alu_and) begin
            res_pre = and_res;
        end
    end

    assign res_data_o = is_slt ? slt_res : res_pre[DATA_W-1:0];

endmodule

// File: design/ex_shifter.sv
`timescale 1ns/1ps

module ex_shifter import ex_pkg::*; (
    input  data_t       src_i,
    input  shamt_t      amt_i,
    input  shift_kind_t kind_i,
    output data_t       res_o
);

    logic  shift_left;
    logic  fill;
    data_t stage [0:6];

    assign shift_left = kind_i == SHIFT_SLL;
    // sign fill only for arithmetic right shifts
    assign fill       = (kind_i == SHIFT_SRA) & src_i[DATA_W-1];

    assign stage[0] = src_i;

    // ==================================================
    // log stages, stage i moves by 2**i
    // ==================================================
    for (genvar i = 0; i < 6; i++) begin : g_stage
        localparam int SH = 1 << i;

        data_t left_val;
        data_t right_val;

        assign left_val  = stage[i] << SH;
        assign right_val = {{SH{fill}}, stage[i][DATA_W-1:SH]};

        assign stage[i+1] = !amt_i[i]   ? stage[i] :
                            shift_left ? left_val :
                                         right_val;
    end

    assign res_o = (kind_i == SHIFT_NONE) ? '0 : stage[6];

endmodule

// File: design/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl import ex_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  wb_adr_t     wb_adr_i,
    input  data_t       wb_dat_i,
    output data_t       wb_dat_o,
    output logic        wb_ack_o,

    output instr_t      instr_o,
    input  alu_op_t     dec_alu_op_i,
    input  logic        dec_slt_signed_i,
    input  logic        dec_slt_unsigned_i,
    input  shift_kind_t dec_shift_kind_i,
    input  logic        dec_use_imm_i,
    input  data_t       dec_imm_i,
    input  logic        dec_word_i,
    input  logic        dec_illegal_i,

    output alu_op_t     alu_op_o,
    output logic        alu_slt_nu_o,
    output logic        alu_slt_u_o,
    output data_t       alu_op1_o,
    output data_t       alu_op2_o,
    input  data_t       alu_res_i,

    output data_t       shift_src_o,
    output shamt_t      shift_amt_o,
    output shift_kind_t shift_kind_o,
    input  data_t       shift_res_i
);

    ctrl_state_t state_q;
    logic        ack_q;
    logic        done_q;
    logic        illegal_q;
    data_t       result_q;
    data_t       op1_q;
    data_t       op2_q;
    instr_t      instr_q;
    data_t       dat_q;

    logic        busy;
    logic        wb_req;
    logic        stall;
    logic        accept;
    logic        instr_wr;
    data_t       status;
    data_t       rd_data;
    data_t       op2_sel;
    data_t       chosen;
    data_t       formatted;

    // ==================================================
    // wishbone slave
    // ==================================================
    assign busy   = state_q == CTRL_ISSUE;
    // the ack cycle itself must not look like a new request
    assign wb_req = wb_cyc_i & wb_stb_i & ~ack_q;

    // result reads and new instructions wait out the issue cycle
    assign stall = busy & ((~wb_we_i & (wb_adr_i == REG_RESULT)) |
                           (wb_we_i & (wb_adr_i == REG_INSTR)));

    assign accept   = wb_req & ~stall;
    assign instr_wr = accept & wb_we_i & (wb_adr_i == REG_INSTR);

    always_comb begin
        status               = '0;
        status[STAT_BUSY]    = busy;
        status[STAT_DONE]    = done_q;
        status[STAT_ILLEGAL] = illegal_q;
    end

    always_comb begin
        case (wb_adr_i)
            REG_OP1:    rd_data = op1_q;
            REG_OP2:    rd_data = op2_q;
            REG_INSTR:  rd_data = {{(DATA_W-32){1'b0}}, instr_q};
            REG_RESULT: rd_data = result_q;
            REG_STATUS: rd_data = status;
            default:    rd_data = '0;
        endcase
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    // ==================================================
    // operand preparation
    // ==================================================
    assign instr_o = instr_q;
    assign op2_sel = dec_use_imm_i ? dec_imm_i : op2_q;

    assign alu_op_o     = dec_alu_op_i;
    assign alu_slt_nu_o = dec_slt_signed_i;
    assign alu_slt_u_o  = dec_slt_unsigned_i;
    assign alu_op1_o    = op1_q;
    assign alu_op2_o    = op2_sel;

    // word shifts only see the low 32 bits of the source
    assign shift_amt_o  = dec_word_i ? {1'b0, op2_sel[4:0]} : op2_sel[5:0];
    assign shift_kind_o = dec_shift_kind_i;

    always_comb begin
        if (!dec_word_i) begin
            shift_src_o = op1_q;
        end else if (dec_shift_kind_i == SHIFT_SRA) begin
            shift_src_o = {{(DATA_W-32){op1_q[31]}}, op1_q[31:0]};
        end else begin
            shift_src_o = {{(DATA_W-32){1'b0}}, op1_q[31:0]};
        end
    end

    assign chosen = (dec_shift_kind_i != SHIFT_NONE) ? shift_res_i : alu_res_i;

    always_comb begin
        if (dec_illegal_i) begin
            formatted = '0;
        end else if (dec_word_i) begin
            formatted = {{(DATA_W-32){chosen[31]}}, chosen[31:0]};
        end else begin
            formatted = chosen;
        end
    end

    // ==================================================
    // control state
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= CTRL_IDLE;
            ack_q     <= 1'b0;
            done_q    <= 1'b0;
            illegal_q <= 1'b0;
            result_q  <= '0;
        end else begin
            ack_q <= accept;
            case (state_q)
                CTRL_ISSUE: begin
                    result_q  <= formatted;
                    illegal_q <= dec_illegal_i;
                    done_q    <= 1'b1;
                    state_q   <= CTRL_DONE;
                end
                default: begin
                    if (instr_wr) begin
                        done_q    <= 1'b0;
                        illegal_q <= 1'b0;
                        state_q   <= CTRL_ISSUE;
                    end
                end
            endcase
        end
    end

    // operand, instruction and read data registers
    always_ff @(posedge clk_i) begin
        if (accept && wb_we_i && wb_adr_i == REG_OP1) begin
            op1_q <= wb_dat_i;
        end
        if (accept && wb_we_i && wb_adr_i == REG_OP2) begin
            op2_q <= wb_dat_i;
        end
        if (instr_wr) begin
            instr_q <= wb_dat_i[31:0];
        end
        if (accept && !wb_we_i) begin
            dat_q <= rd_data;
        end
    end

endmodule

// File: design/ex_top.sv
`timescale 1ns/1ps

module ex_top import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  data_t   wb_dat_i,
    output data_t   wb_dat_o,
    output logic    wb_ack_o
);

    instr_t      instr;

    // decoder outputs
    alu_op_t     dec_alu_op;
    logic        dec_slt_signed;
    logic        dec_slt_unsigned;
    shift_kind_t dec_shift_kind;
    logic        dec_use_imm;
    data_t       dec_imm;
    logic        dec_word;
    logic        dec_illegal;

    // alu side
    alu_op_t     alu_op;
    logic        alu_slt_nu;
    logic        alu_slt_u;
    data_t       alu_op1;
    data_t       alu_op2;
    data_t       alu_res;

    // shifter side
    data_t       shift_src;
    shamt_t      shift_amt;
    shift_kind_t shift_kind;
    data_t       shift_res;

    ex_ctrl ex_ctrl_inst (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .wb_cyc_i           (wb_cyc_i),
        .wb_stb_i           (wb_stb_i),
        .wb_we_i            (wb_we_i),
        .wb_adr_i           (wb_adr_i),
        .wb_dat_i           (wb_dat_i),
        .wb_dat_o           (wb_dat_o),
        .wb_ack_o           (wb_ack_o),
        .instr_o            (instr),
        .dec_alu_op_i       (dec_alu_op),
        .dec_slt_signed_i   (dec_slt_signed),
        .dec_slt_unsigned_i (dec_slt_unsigned),
        .dec_shift_kind_i   (dec_shift_kind),
        .dec_use_imm_i      (dec_use_imm),
        .dec_imm_i          (dec_imm),
        .dec_word_i         (dec_word),
        .dec_illegal_i      (dec_illegal),
        .alu_op_o           (alu_op),
        .alu_slt_nu_o       (alu_slt_nu),
        .alu_slt_u_o        (alu_slt_u),
        .alu_op1_o          (alu_op1),
        .alu_op2_o          (alu_op2),
        .alu_res_i          (alu_res),
        .shift_src_o        (shift_src),
        .shift_amt_o        (shift_amt),
        .shift_kind_o       (shift_kind),
        .shift_res_i        (shift_res)
    );

    ex_decode ex_decode_inst (
        .instr_i        (instr),
        .alu_op_o       (dec_alu_op),
        .slt_signed_o   (dec_slt_signed),
        .slt_unsigned_o (dec_slt_unsigned),
        .shift_kind_o   (dec_shift_kind),
        .use_imm_o      (dec_use_imm),
        .imm_o          (dec_imm),
        .word_o         (dec_word),
        .illegal_o      (dec_illegal)
    );

    ex_alu ex_alu_inst (
        .alu_op_i      (alu_op),
        .inst_slt_nu_i (alu_slt_nu),
        .inst_slt_u_i  (alu_slt_u),
        .op1_i         (alu_op1),
        .op2_i         (alu_op2),
        .res_data_o    (alu_res)
    );

    ex_shifter ex_shifter_inst (
        .src_i  (shift_src),
        .amt_i  (shift_amt),
        .kind_i (shift_kind),
        .res_o  (shift_res)
    );

endmodule

// File: testbench/ex_checker.sv
`timescale 1ns/1ps

module ex_checker import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  data_t   wb_dat_i,
    input  data_t   wb_dat_o,
    input  logic    wb_ack_o,
    output int      error_count_o
);

    int     errors = 0;
    data_t  op1;
    data_t  op2;
    instr_t instr;
    data_t  exp_result;
    logic   exp_illegal;
    logic   exp_done;
    logic   ack_last;

    assign error_count_o = errors;

    // ==================================================
    // reference model of the rv64 integer ops
    // ==================================================
    // returns {illegal, result}
    function automatic logic [DATA_W:0] ref_exec(input instr_t ins, input data_t a,
                                                 input data_t b);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        data_t       imm;
        data_t       res;
        logic [31:0] lo;
        logic        bad;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        imm = {{(DATA_W-12){ins[31]}}, ins[31:20]};
        res = '0;
        lo  = '0;
        bad = 1'b0;
        case (opc)
            7'b0110011: begin
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: res = a + b;
                        3'd1: res = a << b[5:0];
                        3'd2: res = {63'd0, $signed(a) < $signed(b)};
                        3'd3: res = {63'd0, a < b};
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[5:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    res = a - b;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    res = $signed(a) >>> b[5:0];
                end else begin
                    bad = 1'b1;
                end
            end
            7'b0010011: begin
                case (f3)
                    3'd0: res = a + imm;
                    3'd2: res = {63'd0, $signed(a) < $signed(imm)};
                    3'd3: res = {63'd0, a < imm};
                    3'd4: res = a ^ imm;
                    3'd6: res = a | imm;
                    3'd7: res = a & imm;
                    3'd1: begin
                        if (ins[31:26] == 6'b000000) res = a << ins[25:20];
                        else bad = 1'b1;
                    end
                    default: begin
                        if (ins[31:26] == 6'b000000) res = a >> ins[25:20];
                        else if (ins[31:26] == 6'b010000) res = $signed(a) >>> ins[25:20];
                        else bad = 1'b1;
                    end
                endcase
            end
            7'b0111011: begin
                if (f3 == 3'd0 && f7 == 7'h00) lo = a[31:0] + b[31:0];
                else if (f3 == 3'd0 && f7 == 7'h20) lo = a[31:0] - b[31:0];
                else if (f3 == 3'd1 && f7 == 7'h00) lo = a[31:0] << b[4:0];
                else if (f3 == 3'd5 && f7 == 7'h00) lo = a[31:0] >> b[4:0];
                else if (f3 == 3'd5 && f7 == 7'h20) lo = $signed(a[31:0]) >>> b[4:0];
                else bad = 1'b1;
                res = {{32{lo[31]}}, lo};
            end
            7'b0011011: begin
                // word immediate shifts only allow a 5-bit shamt
                if (f3 == 3'd0) lo = a[31:0] + imm[31:0];
                else if (f3 == 3'd1 && f7 == 7'h00) lo = a[31:0] << ins[24:20];
                else if (f3 == 3'd5 && f7 == 7'h00) lo = a[31:0] >> ins[24:20];
                else if (f3 == 3'd5 && f7 == 7'h20) lo = $signed(a[31:0]) >>> ins[24:20];
                else bad = 1'b1;
                res = {{32{lo[31]}}, lo};
            end
            default: bad = 1'b1;
        endcase
        if (bad) res = '0;
        return {bad, res};
    endfunction

    // ==================================================
    // bus monitor, sampled mid-cycle
    // ==================================================
    always @(negedge clk_i) begin
        data_t exp;
        if (reset_i) begin
            op1         <= '0;
            op2         <= '0;
            instr       <= '0;
            exp_result  <= '0;
            exp_illegal <= 1'b0;
            exp_done    <= 1'b0;
            ack_last    <= 1'b0;
        end else begin
            // ack is a single-cycle pulse
            ack_last <= wb_ack_o;
            if (wb_ack_o && ack_last) begin
                errors = errors + 1;
                $display("ack stayed high for more than one cycle at %0t", $time);
            end
            if (wb_ack_o && wb_we_i) begin
                case (wb_adr_i)
                    REG_OP1: op1 <= wb_dat_i;
                    REG_OP2: op2 <= wb_dat_i;
                    REG_INSTR: begin
                        instr <= wb_dat_i[31:0];
                        {exp_illegal, exp_result} <= ref_exec(wb_dat_i[31:0], op1, op2);
                        exp_done <= 1'b1;
                    end
                    default: ;
                endcase
            end else if (wb_ack_o) begin
                case (wb_adr_i)
                    REG_OP1:    exp = op1;
                    REG_OP2:    exp = op2;
                    REG_INSTR:  exp = {32'd0, instr};
                    REG_RESULT: exp = exp_result;
                    REG_STATUS: exp = {61'd0, exp_illegal, exp_done, 1'b0};
                    default:    exp = '0;
                endcase
                if (wb_dat_o !== exp) begin
                    errors = errors + 1;
                    $display("mismatch at %0t: reg %0d read %h, expected %h",
                             $time, wb_adr_i, wb_dat_o, exp);
                end
            end
        end
    end

endmodule

// File: testbench/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top import ex_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 5;
    localparam int NUM_RANDOM      = 300;
    localparam int NUM_DIRECTED    = 40;
    localparam int CYCLES_PER_TEST = 20;
    localparam int TIMEOUT_CYCLES  = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_TEST + 200;

    logic    clk;
    logic    reset;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    data_t   wb_dat_w;
    data_t   wb_dat_r;
    logic    wb_ack;
    int      error_count;
    int      timeouts;

    ex_top ex_top_inst (
        .clk_i    (clk),
        .reset_i  (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    ex_checker ex_checker_inst (
        .clk_i         (clk),
        .reset_i       (reset),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // wishbone master
    // ==================================================
    task automatic wait_ack();
        @(posedge clk);
        #1;
        while (!wb_ack) begin
            @(posedge clk);
            #1;
        end
        #(DRIVE_DELAY - 1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic bus_write(input wb_adr_t adr, input data_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack();
    endtask

    task automatic bus_read(input wb_adr_t adr);
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
    endtask

    task automatic run_instr(input data_t a, input data_t b, input instr_t ins);
        bus_write(REG_OP1, a);
        bus_write(REG_OP2, b);
        bus_write(REG_INSTR, {32'd0, ins});
        // result read follows the instruction write straight away
        bus_read(REG_RESULT);
        bus_read(REG_STATUS);
    endtask

    // ==================================================
    // instruction encoding
    // ==================================================
    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic data_t rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic instr_t random_legal_instr();
        int          grp;
        int          sel;
        logic [11:0] imm;
        logic [5:0]  sh6;
        logic [4:0]  sh5;
        instr_t      ins;
        grp = $urandom % 4;
        sel = $urandom % 10;
        imm = 12'($urandom);
        sh6 = 6'($urandom);
        sh5 = 5'($urandom);
        case (grp)
            0: begin
                if (sel == 1) ins = r_type(7'h20, 3'd0, OPC_OP);
                else if (sel == 7) ins = r_type(7'h20, 3'd5, OPC_OP);
                else if (sel == 8) ins = r_type(7'h00, 3'd1, OPC_OP);
                else if (sel == 9) ins = r_type(7'h00, 3'd7, OPC_OP);
                else ins = r_type(7'h00, 3'(sel), OPC_OP);
            end
            1: begin
                if (sel == 1) ins = i_type({6'b000000, sh6}, 3'd1, OPC_OP_IMM);
                else if (sel == 5) ins = i_type({6'b000000, sh6}, 3'd5, OPC_OP_IMM);
                else if (sel >= 8) ins = i_type({6'b010000, sh6}, 3'd5, OPC_OP_IMM);
                else ins = i_type(imm, 3'(sel), OPC_OP_IMM);
            end
            2: begin
                case (sel % 5)
                    0: ins = r_type(7'h00, 3'd0, OPC_OP_32);
                    1: ins = r_type(7'h20, 3'd0, OPC_OP_32);
                    2: ins = r_type(7'h00, 3'd1, OPC_OP_32);
                    3: ins = r_type(7'h00, 3'd5, OPC_OP_32);
                    default: ins = r_type(7'h20, 3'd5, OPC_OP_32);
                endcase
            end
            default: begin
                case (sel % 4)
                    0: ins = i_type(imm, 3'd0, OPC_OP_IMM_32);
                    1: ins = i_type({7'h00, sh5}, 3'd1, OPC_OP_IMM_32);
                    2: ins = i_type({7'h00, sh5}, 3'd5, OPC_OP_IMM_32);
                    default: ins = i_type({7'h20, sh5}, 3'd5, OPC_OP_IMM_32);
                endcase
            end
        endcase
        return ins;
    endfunction

    task automatic print_summary();
        $display("errors: %0d, timeouts: %0d", error_count, timeouts);
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        void'($urandom(68007));
        timeouts = 0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = REG_OP1;
        wb_dat_w = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // state straight out of reset
        bus_read(REG_STATUS);
        bus_read(REG_RESULT);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_instr(rand64(), rand64(), random_legal_instr());
        end

        // signed against unsigned compare with the top bit set
        run_instr(64'h8000_0000_0000_0000, 64'd1, r_type(7'h00, 3'd2, OPC_OP));
        run_instr(64'h8000_0000_0000_0000, 64'd1, r_type(7'h00, 3'd3, OPC_OP));
        run_instr(64'hFFFF_FFFF_FFFF_FFFE, 64'd0, i_type(12'hFFF, 3'd2, OPC_OP_IMM));
        run_instr(64'h0000_0000_0000_0005, 64'd0, i_type(12'hFFF, 3'd3, OPC_OP_IMM));

        // word forms, shift amounts 31 and 0
        run_instr(64'h1234_5678_7FFF_FFFF, 64'd1, r_type(7'h00, 3'd0, OPC_OP_32));
        run_instr(64'd0, 64'd1, r_type(7'h20, 3'd0, OPC_OP_32));
        run_instr(64'h0000_0000_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF,
                  r_type(7'h00, 3'd1, OPC_OP_32));
        run_instr(64'hFFFF_FFFF_8000_0001, 64'h0000_0000_0000_0020,
                  r_type(7'h00, 3'd1, OPC_OP_32));
        run_instr(64'h0000_0001_8000_0000, 64'd31, r_type(7'h00, 3'd5, OPC_OP_32));
        run_instr(64'h0000_0001_8000_0000, 64'd0, r_type(7'h00, 3'd5, OPC_OP_32));
        run_instr(64'h0000_0000_8000_0000, 64'd31, r_type(7'h20, 3'd5, OPC_OP_32));
        run_instr(64'h0000_0000_8000_0000, 64'd0, r_type(7'h20, 3'd5, OPC_OP_32));
        run_instr(64'h0000_0000_7FFF_FFFF, 64'd0, i_type(12'h001, 3'd0, OPC_OP_IMM_32));
        run_instr(64'h0000_0000_0000_0003, 64'd0, i_type(12'h01F, 3'd1, OPC_OP_IMM_32));
        run_instr(64'hFFFF_FFFF_8000_0000, 64'd0, i_type(12'h01F, 3'd5, OPC_OP_IMM_32));
        run_instr(64'h0000_0000_8000_0000, 64'd0, i_type(12'h41F, 3'd5, OPC_OP_IMM_32));
        run_instr(64'h0000_0000_8000_0000, 64'd0, i_type(12'h400, 3'd5, OPC_OP_IMM_32));

        // illegal encodings, then a legal one clears the flag
        run_instr(rand64(), rand64(), r_type(7'h01, 3'd0, OPC_OP));
        run_instr(rand64(), rand64(), i_type(12'h023, 3'd1, OPC_OP_IMM_32));
        run_instr(rand64(), rand64(), {25'd0, 7'b1111111});
        run_instr(64'd7, 64'd9, r_type(7'h00, 3'd0, OPC_OP));

        // read-only and unmapped writes are dropped
        bus_write(REG_RESULT, 64'hDEAD_BEEF_DEAD_BEEF);
        bus_write(REG_STATUS, 64'hFFFF_FFFF_FFFF_FFFF);
        bus_write(3'd5, 64'h0123_4567_89AB_CDEF);
        bus_write(3'd7, 64'hFEDC_BA98_7654_3210);
        bus_read(REG_RESULT);
        bus_read(REG_STATUS);
        bus_read(REG_OP1);
        bus_read(3'd5);
        bus_read(3'd6);
        bus_read(3'd7);

        // the checker samples the last read on the falling edge
        @(posedge clk);

        print_summary();
        if (error_count == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        timeouts = timeouts + 1;
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
common/ex_pkg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_shifter.sv
design/ex_ctrl.sv
design/ex_top.sv
testbench/ex_checker.sv
testbench/tb_ex_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Mdir obj_dir
TOP       = tb_ex_top
FILELIST  = project.f

.PHONY: sim clean

# the simulator output is shown and searched for the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

clean:
	rm -rf obj_dir
